// File: src.f
+incdir+common
common/tcb_enc_pkg.sv
common/tcb_pkg.sv
source/tcb_dly_line.sv
source/tcb_logsize2byteena.sv
mem/tcb_sram_ben.sv
source/tcb_sub_top.sv
sim/tb_clk_gen.sv
sim/tb_tcb_sub_top.sv

// File: sim/tb_tcb_sub_top.sv
//////////////////////////////////////////////////
// testbench for the TCB subordinate subsystem
// byte array memory model, queue of expected
// responses checked by assertions at negedge
//////////////////////////////////////////////////

`default_nettype none

`include "tcb_cfg.svh"

module tb_tcb_sub_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_NS    = 4;
  localparam int unsigned RAND_REQS = 300;
  // upper bound of all directed requests
  localparam int unsigned DIR_REQS  = 120;
  localparam int unsigned WDOG_CYC  = 10 + DIR_REQS + 2 * RAND_REQS + 6 * 20 + 100;
  localparam int unsigned MEM_BYTES = 4 * `TCB_MEM_WORDS;

  // one expected response
  typedef struct packed {
    logic [31:0] due;
    logic [31:0] rdt;
    logic        sts;
  } exp_t;

  logic                  clk;
  logic                  rst_n;
  logic                  req_vld;
  tcb_pkg::tcb_log_req_t req;
  logic                  rsp_vld;
  tcb_pkg::tcb_rsp_t     rsp;

  logic [7:0]  mem_model [MEM_BYTES];
  exp_t        exp_q [$];
  logic [15:0] lfsr;
  int unsigned cyc = 0;
  int unsigned err_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned tests_run = 0;
  int unsigned tests_bad = 0;
  int unsigned test_base = 0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) i_clk_gen (.clk(clk));

  tcb_sub_top i_tcb_sub_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  //////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // preload pattern that depends on every address bit
  function automatic logic [31:0] fill_word(input int unsigned w);
    logic [31:0] v;
    logic [9:0]  a;
    for (int unsigned k = 0; k < 4; k++) begin
      a = 10'(w * 4 + k);
      v[8*k +: 8] = (a[7:0] ^ {4{a[9:8]}}) + 8'h3c;
    end
    return v;
  endfunction

  // gather old bytes by lane rules and then apply the write
  task automatic model_access(input tcb_pkg::tcb_log_req_t r, output logic [31:0] rdt,
                              output logic sts);
    int unsigned n;
    int unsigned off;
    int unsigned base;
    int unsigned lane;
    n    = 1 << r.siz;
    off  = r.adr % 4;
    base = r.adr - off;
    sts  = (r.siz == 2'd3) || (r.adr >= MEM_BYTES);
    rdt  = '0;
    if (!sts) begin
      for (int unsigned k = 0; k < n; k++) begin
        lane = (r.ndn == tcb_enc_pkg::BIG) ? (off + n - 1 - k) % 4 : (off + k) % 4;
        rdt[8*k +: 8] = mem_model[base + lane];
        if (r.wen) mem_model[base + lane] = r.wdt[k];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////

  always @(posedge clk) cyc <= cyc + 1;

  // outputs and driven inputs are settled mid cycle
  always @(negedge clk) begin : monitor
    exp_t        e;
    logic        due_now;
    logic [31:0] m_rdt;
    logic        m_sts;
    if (rst_n) begin
      due_now = (exp_q.size() != 0) && (exp_q[0].due == cyc);
      assert (rsp_vld === due_now) else begin
        $display("ERROR t=%0t rsp_vld expected %b got %b", $time, due_now, rsp_vld);
        err_cnt++;
      end
      if (due_now) begin
        e = exp_q.pop_front();
        chk_cnt++;
        assert (rsp.sts === e.sts) else begin
          $display("ERROR t=%0t rsp.sts expected %b got %b", $time, e.sts, rsp.sts);
          err_cnt++;
        end
        // bytes never written are unknown in the model
        if (^e.rdt !== 1'bx) begin
          assert (rsp.rdt === e.rdt) else begin
            $display("ERROR t=%0t rsp.rdt expected %h got %h", $time, e.rdt, rsp.rdt);
            err_cnt++;
          end
        end
      end
      // request taken at the coming edge
      if (req_vld) begin
        model_access(req, m_rdt, m_sts);
        exp_q.push_back('{due: cyc + `TCB_DLY, rdt: m_rdt, sts: m_sts});
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic send(input logic wen, input logic ndn, input logic [1:0] siz,
                      input logic [`TCB_ADR_W-1:0] adr, input logic [31:0] wdt);
    @(posedge clk);
    #1;
    req_vld = 1'b1;
    req.wen = wen;
    req.ndn = tcb_enc_pkg::tcb_ndn_t'(ndn);
    req.siz = tcb_enc_pkg::tcb_siz_t'(siz);
    req.adr = adr;
    req.wdt = wdt;
  endtask

  task automatic idle();
    @(posedge clk);
    #1;
    req_vld = 1'b0;
  endtask

  // wait for all outstanding responses
  task automatic drain();
    idle();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name);
    drain();
    tests_run++;
    if (err_cnt == test_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAIL with %0d errors", name, err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : main
    logic [`TCB_ADR_W-1:0] adr;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    lfsr    = 16'd87;
    for (int unsigned i = 0; i < MEM_BYTES; i++) mem_model[i] = 'x;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // quiet after reset and then preload words 0..31
    repeat (5) begin
      @(negedge clk);
      assert (rsp_vld === 1'b0) else begin
        $display("ERROR t=%0t rsp_vld expected 0 got %b", $time, rsp_vld);
        err_cnt++;
      end
    end
    for (int unsigned w = 0; w < 32; w++) send(1'b1, 1'b0, 2'd2, 12'(w * 4), fill_word(w));
    finish_test("reset_and_latency");

    // sized little endian writes with wrapping lanes
    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned o = 0; o < 4; o++) begin
        send(1'b1, 1'b0, 2'(s), 12'((8 + 4 * s + o) * 4 + o), rand_bits(32));
      end
    end
    for (int unsigned w = 8; w < 20; w++) send(1'b0, 1'b0, 2'd2, 12'(w * 4), 32'h0);
    finish_test("little_writes");

    for (int unsigned s = 0; s < 3; s++) begin
      for (int unsigned o = 0; o < 4; o++) begin
        send(1'b0, 1'b1, 2'(s), 12'((20 + 4 * s + o) * 4 + o), 32'h0);
      end
    end
    finish_test("big_reads");

    // reads and writes to one word without gaps
    send(1'b0, 1'b0, 2'd2, 12'd96, 32'h0);
    send(1'b1, 1'b0, 2'd2, 12'd96, rand_bits(32));
    send(1'b0, 1'b0, 2'd2, 12'd96, 32'h0);
    send(1'b1, 1'b0, 2'd0, 12'd97, rand_bits(32));
    send(1'b1, 1'b1, 2'd1, 12'd99, rand_bits(32));
    send(1'b0, 1'b1, 2'd2, 12'd98, 32'h0);
    for (int unsigned i = 0; i < 8; i++) send(i[0], 1'b0, 2'(i % 3), 12'(100 + i), rand_bits(32));
    finish_test("back_to_back");

    // out of range and illegal size then reads proving no write
    send(1'b1, 1'b0, 2'd2, 12'h404, rand_bits(32));
    send(1'b1, 1'b0, 2'd3, 12'h008, rand_bits(32));
    send(1'b0, 1'b0, 2'd2, 12'hffc, 32'h0);
    send(1'b0, 1'b0, 2'd3, 12'h00c, 32'h0);
    send(1'b0, 1'b0, 2'd2, 12'h004, 32'h0);
    send(1'b0, 1'b0, 2'd2, 12'h008, 32'h0);
    finish_test("errors");

    for (int unsigned i = 0; i < RAND_REQS; i++) begin
      adr = 12'(rand_bits(7));
      if (rand_bits(4) == 0) adr = adr | 12'h400;
      send(rand_bits(1), rand_bits(1), 2'(rand_bits(2)), adr, rand_bits(32));
      if (rand_bits(3) == 0) idle();
    end
    finish_test("random_mix");

    $display("%0d tests run, %0d failing, %0d responses checked, %0d errors",
             tests_run, tests_bad, chk_cnt, err_cnt);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // bound on total run length
  initial begin : watchdog
    #(WDOG_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, run stopped", WDOG_CYC);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
//////////////////////////////////////////////////
// testbench clock source
// free running clock, low at time zero
//////////////////////////////////////////////////

`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS = 4
)(
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  // half period per phase
  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// File: source/tcb_sub_top.sv
//////////////////////////////////////////////////
// TCB subordinate subsystem
// log-size requests converted to byte enables
// and served by a 1 KiB SRAM
//////////////////////////////////////////////////

`default_nettype none

module tcb_sub_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // manager request
  input  logic                  req_vld,
  input  tcb_pkg::tcb_log_req_t req,
  // response after the fixed delay
  output logic                  rsp_vld,
  output tcb_pkg::tcb_rsp_t     rsp
);

  // converter to memory
  logic                  ben_vld;
  tcb_pkg::tcb_ben_req_t ben_req;
  // memory back to converter
  tcb_pkg::tcb_rsp_t     mem_rsp;

  //////////////////////////////////////////////////
  // size to byte enable conversion
  //////////////////////////////////////////////////

  tcb_logsize2byteena i_conv (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .ben_vld (ben_vld),
    .ben_req (ben_req),
    .mem_rsp (mem_rsp)
  );

  //////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////

  // response valid left open, the converter
  // times its response with its own metadata line
  tcb_sram_ben i_sram (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (ben_vld),
    .req     (ben_req),
    .rsp_vld (),
    .rsp     (mem_rsp)
  );

endmodule

`default_nettype wire

// File: mem/tcb_sram_ben.sv
//////////////////////////////////////////////////
// TCB byte-enable SRAM
// one cycle read of the old word, per lane writes,
// error on out of range address or empty enables
//////////////////////////////////////////////////

`default_nettype none

`include "tcb_cfg.svh"

module tcb_sram_ben (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  vld,
  input  tcb_pkg::tcb_ben_req_t req,
  output logic                  rsp_vld,
  output tcb_pkg::tcb_rsp_t     rsp
);

  localparam int unsigned BEN   = `TCB_BEN;
  localparam int unsigned ADR_W = `TCB_ADR_W;
  localparam int unsigned WORDS = `TCB_MEM_WORDS;
  localparam int unsigned OFF_W = $clog2(BEN);
  // word index width of the whole bus address space
  localparam int unsigned IDX_W = ADR_W - OFF_W;
  // word index width of the array itself
  localparam int unsigned MEM_W = $clog2(WORDS);

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  logic [IDX_W-1:0] idx;
  logic [MEM_W-1:0] mem_adr;
  logic             err;

  assign idx     = req.adr[ADR_W-1:OFF_W];
  assign mem_adr = idx[MEM_W-1:0];

  // beyond the array, or a transfer with no lanes
  assign err = (idx >= WORDS) || (req.ben == '0);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // contents are not cleared by reset
  logic [BEN-1:0][8-1:0] mem [WORDS];

  // only enabled lanes change
  always_ff @(posedge clk) begin
    if (vld && req.wen && !err) begin
      for (int unsigned i = 0; i < BEN; i++) begin
        if (req.ben[i]) mem[mem_adr][i] <= req.wdt[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  tcb_pkg::tcb_rsp_t rsp_d;

  // read happens before this edge's write lands,
  // so a write also returns the previous word
  always_comb begin
    if (err) begin
      rsp_d.rdt = '0;
      rsp_d.sts = tcb_enc_pkg::ERROR;
    end else begin
      rsp_d.rdt = mem[mem_adr];
      rsp_d.sts = tcb_enc_pkg::OKAY;
    end
  end

  // one cycle of read latency
  tcb_dly_line #(
    .LEN (1),
    .T   (tcb_pkg::tcb_rsp_t)
  ) i_rsp_dly (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .dat     (rsp_d),
    .dly_vld (rsp_vld),
    .dly_dat (rsp)
  );

endmodule

`default_nettype wire

// File: source/tcb_logsize2byteena.sv
//////////////////////////////////////////////////
// TCB log-size to byte-enable converter
// places sized writes on byte lanes rotated by
// the address offset, and gathers the read lanes
// back into a sized value, low byte first
//////////////////////////////////////////////////

`default_nettype none

`include "tcb_cfg.svh"

module tcb_logsize2byteena (
  input  logic                  clk,
  input  logic                  rst_n,
  // log-size side, manager connects here
  input  logic                  req_vld,
  input  tcb_pkg::tcb_log_req_t req,
  output logic                  rsp_vld,
  output tcb_pkg::tcb_rsp_t     rsp,
  // byte-enable side, memory connects here
  output logic                  ben_vld,
  output tcb_pkg::tcb_ben_req_t ben_req,
  input  tcb_pkg::tcb_rsp_t     mem_rsp
);

  localparam int unsigned BEN   = `TCB_BEN;
  localparam int unsigned ADR_W = `TCB_ADR_W;
  // offset bits inside a word
  localparam int unsigned OFF_W = $clog2(BEN);

  //////////////////////////////////////////////////
  // lane helpers
  //////////////////////////////////////////////////

  // value bytes that take part in the transfer
  // illegal size code enables nothing
  function automatic logic [BEN-1:0] siz_msk(input tcb_enc_pkg::tcb_siz_t siz);
    logic [BEN-1:0] msk;
    msk = '0;
    for (int unsigned k = 0; k < BEN; k++) begin
      msk[k] = (siz <= tcb_enc_pkg::WORD) && (k < (1 << siz));
    end
    return msk;
  endfunction

  // lane of value byte k, wraps modulo BEN
  // big endian puts the last value byte on the offset lane
  function automatic logic [OFF_W-1:0] lane_sel(
    input logic [OFF_W-1:0]    off,
    input tcb_enc_pkg::tcb_siz_t siz,
    input tcb_enc_pkg::tcb_ndn_t ndn,
    input int unsigned         k
  );
    logic [OFF_W-1:0] last;
    last = OFF_W'((1 << siz) - 1);
    if (ndn == tcb_enc_pkg::BIG) begin
      return off + last - OFF_W'(k);
    end else begin
      return off + OFF_W'(k);
    end
  endfunction

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  logic [OFF_W-1:0] req_off;
  logic [BEN-1:0]   req_msk;

  assign req_off = req.adr[OFF_W-1:0];
  assign req_msk = siz_msk(req.siz);

  // no stall, every request goes straight through
  assign ben_vld     = req_vld;
  assign ben_req.wen = req.wen;
  // word aligned address toward the memory
  assign ben_req.adr = {req.adr[ADR_W-1:OFF_W], OFF_W'(0)};

  // scatter value bytes onto their lanes
  always_comb begin
    logic [OFF_W-1:0] lane;
    ben_req.ben = '0;
    ben_req.wdt = '0;
    for (int unsigned k = 0; k < BEN; k++) begin
      lane = lane_sel(req_off, req.siz, req.ndn, k);
      if (req_msk[k]) begin
        ben_req.ben[lane] = 1'b1;
        ben_req.wdt[lane] = req.wdt[k];
      end
    end
  end

  //////////////////////////////////////////////////
  // metadata delay
  //////////////////////////////////////////////////

  tcb_pkg::tcb_meta_t req_meta;
  tcb_pkg::tcb_meta_t rsp_meta;

  assign req_meta = '{off: req_off, siz: req.siz, ndn: req.ndn};

  // lines up with the memory response, also gives rsp_vld
  tcb_dly_line #(
    .LEN (`TCB_DLY),
    .T   (tcb_pkg::tcb_meta_t)
  ) i_meta_dly (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (req_vld),
    .dat     (req_meta),
    .dly_vld (rsp_vld),
    .dly_dat (rsp_meta)
  );

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  logic [BEN-1:0] rsp_msk;

  assign rsp_msk = siz_msk(rsp_meta.siz);

  // gather lanes back, bytes above the size read zero
  always_comb begin
    logic [OFF_W-1:0] lane;
    rsp.rdt = '0;
    for (int unsigned k = 0; k < BEN; k++) begin
      lane = lane_sel(rsp_meta.off, rsp_meta.siz, rsp_meta.ndn, k);
      if (rsp_msk[k]) rsp.rdt[k] = mem_rsp.rdt[lane];
    end
  end

  // memory status goes back unchanged
  assign rsp.sts = mem_rsp.sts;

endmodule

`default_nettype wire

// File: source/tcb_dly_line.sv
//////////////////////////////////////////////////
// TCB delay line
// fixed length pipeline of a payload of any type,
// each stage carrying its own valid bit
//////////////////////////////////////////////////

`default_nettype none

module tcb_dly_line #(
  parameter int unsigned LEN = 1,
  parameter type         T   = logic
)(
  input  logic clk,
  input  logic rst_n,
  input  logic vld,
  input  T     dat,
  output logic dly_vld,
  output T     dly_dat
);

  // stage valid bits, stage 0 is nearest the input
  logic [LEN-1:0] vld_q;
  // stage payload
  T               dat_q [LEN];

  // valid shift, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= vld;
      for (int i = 1; i < LEN; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // payload only moves along with a valid
  always_ff @(posedge clk) begin
    if (vld) dat_q[0] <= dat;
    for (int i = 1; i < LEN; i++) begin
      if (vld_q[i-1]) dat_q[i] <= dat_q[i-1];
    end
  end

  // last stage
  assign dly_vld = vld_q[LEN-1];
  assign dly_dat = dat_q[LEN-1];

endmodule

`default_nettype wire

// File: common/tcb_pkg.sv
//////////////////////////////////////////////////
// TCB transfer types
// log-size and byte-enable requests, responses
// and request metadata carried to the response
//////////////////////////////////////////////////

`default_nettype none

`include "tcb_cfg.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // requests
  //////////////////////////////////////////////////

  // log-size mode, value sits in the low bytes of wdt
  typedef struct packed {
    logic                          wen;
    tcb_enc_pkg::tcb_ndn_t         ndn;
    tcb_enc_pkg::tcb_siz_t         siz;
    logic [`TCB_ADR_W-1:0]         adr;
    logic [`TCB_BEN-1:0][8-1:0]    wdt;
  } tcb_log_req_t;

  // byte-enable mode, word aligned address
  // data already placed on its byte lanes
  typedef struct packed {
    logic                          wen;
    logic [`TCB_ADR_W-1:0]         adr;
    logic [`TCB_BEN-1:0]           ben;
    logic [`TCB_BEN-1:0][8-1:0]    wdt;
  } tcb_ben_req_t;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [`TCB_BEN-1:0][8-1:0]    rdt;
    tcb_enc_pkg::tcb_sts_t         sts;
  } tcb_rsp_t;

  // what the read path needs to undo the lane rotation
  typedef struct packed {
    logic [$clog2(`TCB_BEN)-1:0]   off;
    tcb_enc_pkg::tcb_siz_t         siz;
    tcb_enc_pkg::tcb_ndn_t         ndn;
  } tcb_meta_t;

endpackage

`default_nettype wire

// File: common/tcb_enc_pkg.sv
//////////////////////////////////////////////////
// TCB bus encodings
// access size codes, byte order and status
//////////////////////////////////////////////////

`default_nettype none

package tcb_enc_pkg;

  //////////////////////////////////////////////////
  // access size
  //////////////////////////////////////////////////

  // log2 of the number of bytes in the transfer
  // code 3 is not a legal size
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } tcb_siz_t;

  //////////////////////////////////////////////////
  // byte order
  //////////////////////////////////////////////////

  typedef enum logic {
    LITTLE = 1'b0,
    BIG    = 1'b1
  } tcb_ndn_t;

  //////////////////////////////////////////////////
  // response status
  //////////////////////////////////////////////////

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } tcb_sts_t;

endpackage

`default_nettype wire

// File: common/tcb_cfg.svh
//////////////////////////////////////////////////
// TCB subsystem configuration
// bus widths, response delay and memory depth
//////////////////////////////////////////////////

`ifndef TCB_CFG_SVH
`define TCB_CFG_SVH

// byte address width, 4 KiB address space
`define TCB_ADR_W 12

// bytes per data word, data width is 8x this
`define TCB_BEN 4

// cycles from request to response
`define TCB_DLY 1

// SRAM depth in words, 1 KiB
`define TCB_MEM_WORDS 256

`endif
